// ==== Makefile ====
# Verilator build of the tag tracker testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = tag_tracker_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only if the pass message shows up as a line of its own
run: compile
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tag_tracker_tb.sv ====
// ==================================================================
// Testbench for the tag tracker top level
// Inputs change on the falling edge, outputs are sampled there too
// Stimulus decisions are taken at the rising edge on a stable model
// Alloc tags come from the DUT and are checked against the model
// Stops at the first mismatch, a watchdog bounds the run
// ==================================================================
`timescale 1ns/100ps
`default_nettype none

module tag_tracker_tb import tag_pkg::*;
();

    localparam int ALLOC_LIMIT   = N_TAGS - 2 - MIN_FREE;
    localparam int N_RANDOM      = 2000;
    localparam int DIRECTED_CMDS = 150;
    localparam int WATCHDOG_CYC  = (DIRECTED_CMDS + N_RANDOM) * 4 + 200;
    localparam int RAND_SEED     = 32'h4823;

    // Expected response, new_tag marks an alloc whose tag the DUT picks
    typedef struct packed {
        int    due;
        op_t   op;
        tag_t  tag;
        data_t data;
        logic  err;
        logic  new_tag;
    } rsp_t;

    logic  clk = 1'b0;
    logic  reset;
    logic  cmd_valid;
    op_t   cmd_op;
    tag_t  cmd_tag;
    data_t cmd_data;
    logic  not_full;
    logic  rsp_valid;
    op_t   rsp_op;
    tag_t  rsp_tag;
    data_t rsp_data;
    logic  rsp_err;

    // Reference model state
    bit    in_use    [0:N_TAGS-1];
    bit    avail     [0:N_TAGS-1];
    data_t word      [0:N_TAGS-1];
    int    outstanding = 0;
    int    cycle       = 0;
    rsp_t  expect_q [$];

    tag_tracker_top tag_tracker_top_i
    (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_tag   (cmd_tag),
        .cmd_data  (cmd_data),
        .not_full  (not_full),
        .rsp_valid (rsp_valid),
        .rsp_op    (rsp_op),
        .rsp_tag   (rsp_tag),
        .rsp_data  (rsp_data),
        .rsp_err   (rsp_err)
    );

    // 20 ns clock
    always #10 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    // ==================================================================
    // Error handling and compare tasks
    // ==================================================================
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp);
        if (got !== exp)
            fail_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp)
            fail_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_op(input string name, input op_t got, input op_t exp);
        if (got !== exp)
            fail_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // ==================================================================
    // Reference model
    // ==================================================================
    // Refused alloc once the heap holds its limit, tag and data zero
    function automatic rsp_t predict_rsp(input op_t op, input tag_t tag, input data_t data,
                                         input int in_flight, input data_t stored);
        rsp_t r;
        r         = '0;
        r.op      = op;
        r.tag     = tag;
        if (op == OP_ALLOC)
        begin
            r.tag = '0;
            if (in_flight >= ALLOC_LIMIT)
                r.err = 1'b1;
            else
            begin
                r.new_tag = 1'b1;
                r.data    = data;
            end
        end
        else if (op == OP_LOOKUP)
            r.data = stored;
        return r;
    endfunction

    function automatic int count_avail();
        int n;
        int k;
        n = 0;
        for (k = 0; k < N_TAGS; k++)
            n += int'(avail[k]);
        return n;
    endfunction

    // Random tag that is in use and has no release pending
    function automatic tag_t pick_tag();
        int start;
        int k;
        start = int'($urandom_range(N_TAGS - 1, 0));
        for (k = 0; k < N_TAGS; k++)
        begin
            if (avail[(start + k) % N_TAGS])
                return tag_t'((start + k) % N_TAGS);
        end
        return '0;
    endfunction

    // ==================================================================
    // Stimulus tasks, called just after a rising edge
    // ==================================================================
    task automatic send_cmd(input bit valid, input op_t op, input tag_t tag, input data_t data);
        rsp_t exp;
        exp = predict_rsp(op, tag, data, outstanding, word[tag]);
        if (valid && (op == OP_ALLOC) && !exp.err)
            outstanding++;
        if (valid && (op == OP_RELEASE))
            avail[tag] = 1'b0;
        @(negedge clk);
        cmd_valid = valid;
        cmd_op    = op;
        cmd_tag   = tag;
        cmd_data  = data;
        if (valid)
        begin
            exp.due = cycle + RSP_LATENCY;
            expect_q.push_back(exp);
        end
    endtask

    task automatic issue_cmd(input op_t op);
        @(posedge clk);
        if (op == OP_ALLOC)
            send_cmd(1'b1, op, '0, data_t'($urandom()));
        else
            send_cmd(1'b1, op, pick_tag(), data_t'($urandom()));
    endtask

    // Go idle and wait for every response to come back
    task automatic wait_idle();
        @(posedge clk);
        send_cmd(1'b0, OP_NOP, '0, '0);
        while (expect_q.size() != 0)
            @(posedge clk);
    endtask

    task automatic release_all();
        while (count_avail() > 0)
            issue_cmd(OP_RELEASE);
        wait_idle();
    endtask

    task automatic wait_init();
        int n;
        n = 0;
        while (!not_full && (n < N_TAGS + 4))
        begin
            @(negedge clk);
            n++;
        end
        if (!not_full)
            fail_run("not_full did not rise within N_TAGS+4 cycles after reset");
        if (n < N_TAGS / 2)
            fail_run("not_full rose before the init sweep could have finished");
    endtask

    task automatic run_random(input int n_cmds);
        int   kind;
        int   i;
        tag_t tag;
        for (i = 0; i < n_cmds; i++)
        begin
            @(posedge clk);
            kind = int'($urandom_range(9, 0));
            tag  = pick_tag();
            if ((kind < 4) && (outstanding < ALLOC_LIMIT))
                send_cmd(1'b1, OP_ALLOC, tag_t'($urandom()), data_t'($urandom()));
            else if ((kind < 7) && (count_avail() > 0))
                send_cmd(1'b1, OP_LOOKUP, tag, data_t'($urandom()));
            else if ((kind < 9) && (count_avail() > 0))
                send_cmd(1'b1, OP_RELEASE, tag, '0);
            else if (kind == 9)
                send_cmd(1'b1, OP_NOP, tag, '0);
            else
                send_cmd(1'b0, OP_NOP, '0, '0);
        end
    endtask

    // ==================================================================
    // Response compare, at the falling edge
    // ==================================================================
    always @(negedge clk)
    begin : compare_rsp
        rsp_t exp;
        if (reset)
        begin
            check_flag("rsp_valid", rsp_valid, 1'b0);
            check_flag("not_full", not_full, 1'b0);
        end
        else if ((expect_q.size() != 0) && (expect_q[0].due == cycle))
        begin
            exp = expect_q.pop_front();
            check_flag("rsp_valid", rsp_valid, 1'b1);
            check_op("rsp_op", rsp_op, exp.op);
            check_flag("rsp_err", rsp_err, exp.err);
            check_data("rsp_data", rsp_data, exp.data);
            if (exp.new_tag)
            begin
                if ($isunknown(rsp_tag))
                    fail_run("alloc response carries an unknown tag");
                // New tag must be free in the model
                check_flag("in_use of new rsp_tag", in_use[rsp_tag], 1'b0);
                in_use[rsp_tag]    = 1'b1;
                avail[rsp_tag]     = 1'b1;
                word[rsp_tag]      = exp.data;
            end
            else
                check_tag("rsp_tag", rsp_tag, exp.tag);
            if (exp.op == OP_RELEASE)
            begin
                in_use[exp.tag] = 1'b0;
                outstanding--;
            end
        end
        else
            check_flag("rsp_valid", rsp_valid, 1'b0);
    end

    initial
    begin : watchdog
        repeat (WATCHDOG_CYC) @(posedge clk);
        fail_run("watchdog timeout, responses stopped or the run took too long");
    end

    // ==================================================================
    // Test sequence
    // ==================================================================
    initial
    begin : stimulus
        int i;
        void'($urandom(RAND_SEED));
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = OP_NOP;
        cmd_tag   = '0;
        cmd_data  = '0;
        for (i = 0; i < N_TAGS; i++)
        begin
            in_use[i]    = 1'b0;
            avail[i]     = 1'b0;
            word[i]      = '0;
        end

        repeat (4) @(negedge clk);
        reset = 1'b0;
        wait_init();

        // Allocs, then lookups mixed with allocs back to back
        for (i = 0; i < 8; i++)
            issue_cmd(OP_ALLOC);
        wait_idle();
        for (i = 0; i < 8; i++)
        begin
            issue_cmd(OP_LOOKUP);
            issue_cmd(OP_ALLOC);
        end
        wait_idle();

        // Release, alloc again, then read back
        for (i = 0; i < 4; i++)
            issue_cmd(OP_RELEASE);
        for (i = 0; i < 4; i++)
            issue_cmd(OP_ALLOC);
        wait_idle();
        for (i = 0; i < 6; i++)
            issue_cmd(OP_LOOKUP);
        wait_idle();
        release_all();

        // Fill one at a time, the last alloc is refused
        for (i = 0; i <= ALLOC_LIMIT; i++)
        begin
            issue_cmd(OP_ALLOC);
            wait_idle();
        end
        issue_cmd(OP_RELEASE);
        wait_idle();
        repeat (2) @(posedge clk);
        issue_cmd(OP_ALLOC);
        wait_idle();
        release_all();

        run_random(N_RANDOM);
        wait_idle();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/cmd_decode.sv ====
// ==================================================================
// Decode stage, registers one host command per cycle
// Heap strobes are active in the cycle after the command edge
// An alloc seen while not_full is low is refused and flagged in err
// not_full is registered in the heap, so one alloc past the limit
// can still get through, MIN_FREE covers that slack
// ==================================================================
`timescale 1ns/100ps
`default_nettype none

module cmd_decode import tag_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // Host command
    input  logic       cmd_valid,
    input  op_t        cmd_op,
    input  tag_t       cmd_tag,
    input  data_t      cmd_data,

    heap_ctl_if.decode ctl,
    stage_if.source    stg
);

    // Registered command
    logic  valid_q;
    op_t   op_q;
    logic  err_q;
    tag_t  tag_q;
    data_t data_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_q <= 1'b0;
            op_q    <= OP_NOP;
            err_q   <= 1'b0;
        end
        else
        begin
            valid_q <= cmd_valid;
            op_q    <= cmd_op;
            // Full is judged against not_full at this same edge
            err_q   <= cmd_valid && (cmd_op == OP_ALLOC) && !ctl.not_full;
        end

        tag_q  <= cmd_tag;
        data_q <= cmd_data;
    end

    // Heap strobes, refused allocs take no entry
    assign ctl.alloc       = valid_q && (op_q == OP_ALLOC) && !err_q;
    assign ctl.alloc_data  = data_q;
    assign ctl.release_en  = valid_q && (op_q == OP_RELEASE);
    assign ctl.release_tag = tag_q;

    // Heap reads every cycle, only lookups use the result
    assign ctl.lookup_tag  = tag_q;

    // Command record for the result stage
    assign stg.valid = valid_q;
    assign stg.op    = op_q;
    assign stg.tag   = tag_q;
    assign stg.err   = err_q;

endmodule

`default_nettype wire

// ==== src/rsp_format.sv ====
// ==================================================================
// Result stage, two register stages behind the decode record
// Stage 1 takes the alloc tag and the echoed word
// Stage 2 takes the lookup data and drives the response
// Refused allocs answer with tag and data zero and err set
// Release and nop answer with their own tag and data zero
// ==================================================================
`timescale 1ns/100ps
`default_nettype none

module rsp_format import tag_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    heap_ctl_if.result ctl,
    stage_if.sink      stg,

    // Response stream, in command order
    output logic       rsp_valid,
    output op_t        rsp_op,
    output tag_t       rsp_tag,
    output data_t      rsp_data,
    output logic       rsp_err
);

    // Stage 1 record
    logic  s1_valid;
    op_t   s1_op;
    tag_t  s1_tag;
    data_t s1_data;
    logic  s1_err;

    // Stage 1, alloc results are only valid in the strobe cycle
    always_ff @(posedge clk)
    begin
        if (reset)
            s1_valid <= 1'b0;
        else
            s1_valid <= stg.valid;

        s1_op  <= stg.op;
        s1_err <= stg.err;

        if ((stg.op == OP_ALLOC) && !stg.err)
        begin
            s1_tag  <= ctl.alloc_tag;
            s1_data <= ctl.alloc_data;
        end
        else if (stg.op == OP_ALLOC)
        begin
            s1_tag  <= '0;
            s1_data <= '0;
        end
        else
        begin
            s1_tag  <= stg.tag;
            s1_data <= '0;
        end
    end

    // Stage 2, lookup data arrives one cycle after lookup_tag
    always_ff @(posedge clk)
    begin
        if (reset)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= s1_valid;

        rsp_op   <= s1_op;
        rsp_tag  <= s1_tag;
        rsp_err  <= s1_err;
        rsp_data <= (s1_op == OP_LOOKUP) ? ctl.lookup_data : s1_data;
    end

endmodule

`default_nettype wire

// ==== src/simple_ram.sv ====
// ==================================================================
// Simple dual port RAM, one write port and one read port
// Read data is registered and arrives one cycle after raddr
// Read and write of the same address return the old contents
// No reset, contents are unknown until written
// ==================================================================
`timescale 1ns/100ps
`default_nettype none

module simple_ram
#(
    parameter int DEPTH = 32,
    parameter int WIDTH = 32
)
(
    input  logic                     clk,

    // Write port
    input  logic                     wen,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [WIDTH-1:0]         wdata,

    // Read port
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [WIDTH-1:0]         rdata
);

    // Storage array
    logic [WIDTH-1:0] mem [0:DEPTH-1];

    // Write and read share one process so a colliding read sees old data
    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[waddr] <= wdata;
        end

        // Registered read, one cycle of latency
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// ==== src/tag_heap.sv ====
// ==================================================================
// Execute stage, round robin heap of tags with one word per tag
// Two free list heads and two tails hide the free list read latency
// Entries 0 and 1 start as heads, a sweep links 2 to N_TAGS-1 after
// reset, and not_full stays low until the sweep is done
// Two entries stay in reserve so neither head ever runs empty
// A release reaches the free list and the counter one cycle later
// Releasing a tag that is not in use corrupts the free list
// ==================================================================
`timescale 1ns/100ps
`default_nettype none

module tag_heap import tag_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    heap_ctl_if.heap ctl
);

    // Free list heads, tails and round robin selects
    tag_t head_reg [0:1];
    tag_t head     [0:1];
    tag_t tail     [0:1];
    logic head_sel;
    logic head_sel_q;
    logic tail_sel;
    logic alloc_q;

    // Init sweep
    logic initialized;
    tag_t init_idx;

    // Free list RAM ports
    logic free_wen;
    tag_t free_wdata;
    tag_t free_rnext;

    // Delayed release
    logic release_q;
    tag_t release_tag_q;

    // Free entries beyond the two in reserve
    tag_t num_free;
    logic not_full_r;

    // ==================================================================
    // Data memory, written at alloc, read by lookup_tag
    // ==================================================================
    simple_ram #(.DEPTH(N_TAGS), .WIDTH(DATA_W)) data_ram_i
    (
        .clk   (clk),
        .wen   (ctl.alloc),
        .waddr (ctl.alloc_tag),
        .wdata (ctl.alloc_data),
        .raddr (ctl.lookup_tag),
        .rdata (ctl.lookup_data)
    );

    // ==================================================================
    // Free list, each entry holds the next free tag of its list
    // ==================================================================
    simple_ram #(.DEPTH(N_TAGS), .WIDTH(TAG_W)) free_ram_i
    (
        .clk   (clk),
        .wen   (free_wen),
        .waddr (tail[tail_sel]),
        .wdata (free_wdata),
        .raddr (head[head_sel]),
        .rdata (free_rnext)
    );

    // Current head of the selected list
    assign ctl.alloc_tag = head[head_sel];

    // List popped last cycle takes the next pointer read from the RAM
    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            if (alloc_q && (head_sel_q == 1'(i)))
                head[i] = free_rnext;
            else
                head[i] = head_reg[i];
        end
    end

    // Pop side
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            head_reg[0] <= tag_t'(0);
            head_reg[1] <= tag_t'(1);
            head_sel    <= 1'b0;
            head_sel_q  <= 1'b0;
            alloc_q     <= 1'b0;
        end
        else
        begin
            head_reg[0] <= head[0];
            head_reg[1] <= head[1];
            head_sel_q  <= head_sel;
            alloc_q     <= ctl.alloc;
            // Alternate lists on every pop
            if (ctl.alloc)
                head_sel <= ~head_sel;
        end
    end

    // Push side, the sweep owns the write port until initialized
    always_ff @(posedge clk)
    begin
        if (reset)
            release_q <= 1'b0;
        else
            release_q <= ctl.release_en;

        release_tag_q <= ctl.release_tag;
    end

    assign free_wen   = !initialized || release_q;
    assign free_wdata = initialized ? release_tag_q : init_idx;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tail[0]  <= tag_t'(0);
            tail[1]  <= tag_t'(1);
            tail_sel <= 1'b0;
        end
        else if (free_wen)
        begin
            // Pushed entry becomes the new tail, then swap lists
            tail[tail_sel] <= free_wdata;
            tail_sel       <= ~tail_sel;
        end
    end

    // ==================================================================
    // Init sweep and free counter
    // ==================================================================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            init_idx    <= tag_t'(2);
            initialized <= 1'b0;
            num_free    <= '0;
            not_full_r  <= 1'b0;
        end
        else if (!initialized)
        begin
            init_idx <= init_idx + tag_t'(1);
            if (init_idx == tag_t'(N_TAGS - 1))
            begin
                initialized <= 1'b1;
                num_free    <= tag_t'(N_TAGS - 2);
                not_full_r  <= 1'b1;
            end
        end
        else if (release_q && !ctl.alloc)
        begin
            num_free   <= num_free + tag_t'(1);
            not_full_r <= (num_free + tag_t'(1)) > tag_t'(MIN_FREE);
        end
        else if (!release_q && ctl.alloc)
        begin
            num_free   <= num_free - tag_t'(1);
            not_full_r <= (num_free - tag_t'(1)) > tag_t'(MIN_FREE);
        end
    end

    assign ctl.not_full = not_full_r;

    // Alloc from an empty heap
    a_no_empty_alloc: assert property (@(posedge clk) disable iff (reset)
        (ctl.alloc && !release_q) |-> (num_free != '0));

    // Counter overflow means a tag was pushed twice
    a_no_over_release: assert property (@(posedge clk) disable iff (reset)
        (release_q && !ctl.alloc) |-> (num_free < tag_t'(N_TAGS - 2)));

    // Decode must hold off until the sweep is done
    a_no_early_strobe: assert property (@(posedge clk) disable iff (reset)
        !initialized |-> !(ctl.alloc || ctl.release_en));

endmodule

`default_nettype wire

// ==== src/tag_pkg.sv ====
// ==================================================================
// Shared widths, sizes, op codes and types of the tag tracker
// N_TAGS must be a power of two and larger than 2 + MIN_FREE
// Two entries always stay on the free list, so at most N_TAGS-2 are
// handed out, and allocs stop once MIN_FREE or fewer remain
// ==================================================================
`default_nettype none

package tag_pkg;

    // Heap geometry
    localparam int N_TAGS      = 32;
    localparam int MIN_FREE    = 1;
    localparam int DATA_W      = 32;
    localparam int TAG_W       = $clog2(N_TAGS);
    localparam int OP_W        = 2;

    // Command to response, in cycles
    localparam int RSP_LATENCY = 3;

    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [OP_W-1:0]   op_t;

    // Command codes
    localparam op_t OP_NOP     = 2'd0;
    localparam op_t OP_ALLOC   = 2'd1;
    localparam op_t OP_LOOKUP  = 2'd2;
    localparam op_t OP_RELEASE = 2'd3;

endpackage

`default_nettype wire

// ==== src/tag_tracker_top.sv ====
// ==================================================================
// Tag tracker top, decode, heap and result stages in a line
// One command per cycle, response three cycles after the command
// No back-pressure on responses
// Host must not send commands before not_full first goes high
// ==================================================================
`timescale 1ns/100ps
`default_nettype none

module tag_tracker_top import tag_pkg::*;
(
    input  logic  clk,
    input  logic  reset,

    // Host command
    input  logic  cmd_valid,
    input  op_t   cmd_op,
    input  tag_t  cmd_tag,
    input  data_t cmd_data,

    // Heap status
    output logic  not_full,

    // Response stream
    output logic  rsp_valid,
    output op_t   rsp_op,
    output tag_t  rsp_tag,
    output data_t rsp_data,
    output logic  rsp_err
);

    heap_ctl_if ctl_if ();
    stage_if    stg_if ();

    // Decode stage
    cmd_decode cmd_decode_i
    (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_tag   (cmd_tag),
        .cmd_data  (cmd_data),
        .ctl       (ctl_if),
        .stg       (stg_if)
    );

    // Execute stage
    tag_heap tag_heap_i
    (
        .clk   (clk),
        .reset (reset),
        .ctl   (ctl_if)
    );

    // Result stage
    rsp_format rsp_format_i
    (
        .clk       (clk),
        .reset     (reset),
        .ctl       (ctl_if),
        .stg       (stg_if),
        .rsp_valid (rsp_valid),
        .rsp_op    (rsp_op),
        .rsp_tag   (rsp_tag),
        .rsp_data  (rsp_data),
        .rsp_err   (rsp_err)
    );

    assign not_full = ctl_if.not_full;

endmodule

`default_nettype wire

// ==== src/tracker_ifs.sv ====
// ==================================================================
// Interfaces between the decode, heap and result stages
// heap_ctl_if carries the heap strobes and the heap results
// stage_if carries the registered command record to the result stage
// ==================================================================
`timescale 1ns/100ps
`default_nettype none

interface heap_ctl_if import tag_pkg::*;
    ;

    // Decode to heap, valid in the cycle after the command edge
    logic  alloc;
    data_t alloc_data;
    tag_t  lookup_tag;
    logic  release_en;
    tag_t  release_tag;

    // Heap results
    tag_t  alloc_tag;
    data_t lookup_data;
    logic  not_full;

    modport decode (output alloc, alloc_data, lookup_tag, release_en, release_tag,
                    input  not_full);

    modport heap   (input  alloc, alloc_data, lookup_tag, release_en, release_tag,
                    output alloc_tag, lookup_data, not_full);

    // Result stage picks up the new tag, the echoed word and read data
    modport result (input  alloc_tag, alloc_data, lookup_data);

endinterface

interface stage_if import tag_pkg::*;
    ;

    logic valid;
    op_t  op;
    tag_t tag;
    // Set for an alloc refused while the heap was full
    logic err;

    modport source (output valid, op, tag, err);
    modport sink   (input  valid, op, tag, err);

endinterface

`default_nettype wire

// ==== tb.f ====
src/tag_pkg.sv
src/tracker_ifs.sv
src/simple_ram.sv
src/cmd_decode.sv
src/tag_heap.sv
src/rsp_format.sv
src/tag_tracker_top.sv
dv/tag_tracker_tb.sv
